/* Bender.yml */
package:
  name: irq_sleep

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/irq_pkg.sv
      - irq/irq_csr.sv
      - irq/irq_arbiter.sv
      - sleep/wfi_sleep_ctrl.sv
      - hdl/obi_outstanding_counter.sv
      - hdl/irq_sleep_top.sv
  - target: test
    include_dirs:
      - common
      - testbench
    files:
      - testbench/tb_irq_sleep.sv

/* common/irq_macros.svh */
/*
 * Interrupt and sleep unit constants
 * Line count, implemented-line mask, wait encodings,
 * sleep settle delay and OBI counter width
 */
`ifndef IRQ_MACROS_SVH
`define IRQ_MACROS_SVH

// Number of interrupt lines into MIP
`define IRQ_NUM 32

// Implemented lines
// 31..16 platform, 11 external, 7 timer, 3 software
`define IRQ_VALID_MASK 32'hFFFF_0888

// Wait instruction encodings as seen in writeback
`define WFI_INSTR 32'h1050_0073
`define WFE_INSTR 32'h8C00_0073

// Extra cycles a qualified wait sits in writeback before sleep
`define SLEEP_DELAY 2

// Width of each outstanding-transaction counter
`define OBI_CNT_W 4

`endif

/* common/irq_pkg.sv */
/*
 * Interrupt and sleep unit types
 * Privilege, MPU result, CSR select, writeback opcode class,
 * sleep FSM state and interrupt number
 */
`default_nettype none

package irq_pkg;

  // Privilege level as driven by the core
  typedef enum logic [1:0] {
    PRIV_LVL_U = 2'b00,
    PRIV_LVL_M = 2'b11
  } priv_lvl_e;

  // MPU verdict for the instruction in writeback
  typedef enum logic [1:0] {
    MPU_OK       = 2'b00,
    MPU_RE_FAULT = 2'b01,
    MPU_WR_FAULT = 2'b10
  } mpu_status_e;

  // CSRs owned by this unit
  typedef enum logic [1:0] {
    CSR_MSTATUS = 2'b00,
    CSR_MIE     = 2'b01,
    CSR_MIP     = 2'b10
  } csr_addr_e;

  // Writeback opcode class, only the wait instructions matter here
  typedef enum logic [1:0] {
    INSTR_OTHER = 2'b00,
    INSTR_WFI   = 2'b01,
    INSTR_WFE   = 2'b10
  } instr_kind_e;

  // Sleep FSM
  typedef enum logic [1:0] {
    SLEEP_AWAKE  = 2'b00,
    SLEEP_SETTLE = 2'b01,
    SLEEP_ASLEEP = 2'b10
  } sleep_state_e;

  // Interrupt number, 0 to 31
  typedef logic [4:0] irq_id_t;

endpackage

`default_nettype wire

/* flist.f */
+incdir+common
+incdir+testbench
common/irq_pkg.sv
irq/irq_csr.sv
irq/irq_arbiter.sv
sleep/wfi_sleep_ctrl.sv
hdl/obi_outstanding_counter.sv
hdl/irq_sleep_top.sv
testbench/tb_irq_sleep.sv

/* hdl/irq_sleep_top.sv */
/*
 * Machine-mode interrupt and sleep unit
 * CSR block, priority arbiter, per-side OBI counters
 * and the WFI/WFE sleep controller
 */
`timescale 1ns/100ps
`default_nettype none

`include "irq_macros.svh"

module irq_sleep_top (
  input  wire                  clk_i,
  input  wire                  rst_ni,
  // Interrupt lines and core handshake
  input  wire [`IRQ_NUM-1:0]   irq_i,
  input  wire                  irq_ready_i,
  output logic                 irq_valid_o,
  output irq_pkg::irq_id_t     irq_id_o,
  output logic                 irq_ack_o,
  // CSR access
  input  wire                  csr_we_i,
  input  irq_pkg::csr_addr_e   csr_addr_i,
  input  wire [31:0]           csr_wdata_i,
  output logic [31:0]          csr_rdata_o,
  input  wire                  mret_i,
  input  irq_pkg::priv_lvl_e   priv_lvl_i,
  input  wire                  mstatus_tw_i,
  // Writeback stage
  input  wire                  wb_valid_i,
  input  wire [31:0]           wb_instr_i,
  input  wire                  wb_err_i,
  input  irq_pkg::mpu_status_e wb_mpu_status_i,
  input  wire                  wb_kill_i,
  // Debug
  input  wire                  debug_mode_i,
  input  wire                  debug_req_i,
  input  wire                  dcsr_step_i,
  // OBI instruction and data sides
  input  wire                  iside_req_i,
  input  wire                  iside_gnt_i,
  input  wire                  iside_rvalid_i,
  input  wire                  dside_req_i,
  input  wire                  dside_gnt_i,
  input  wire                  dside_rvalid_i,
  input  wire                  wbuf_empty_i,
  output logic                 core_sleep_o
);

  logic [31:0] mip;
  logic [31:0] mie;
  logic        mstatus_mie;
  logic        trap;
  logic        irq_pending;
  logic        iside_busy;
  logic        dside_busy;

  // --------------------------------------------------
  // Interrupt path
  // --------------------------------------------------
  irq_csr u_csr (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .irq_i         (irq_i),
    .csr_we_i      (csr_we_i),
    .csr_addr_i    (csr_addr_i),
    .csr_wdata_i   (csr_wdata_i),
    .trap_i        (trap),
    .mret_i        (mret_i),
    .csr_rdata_o   (csr_rdata_o),
    .mip_o         (mip),
    .mie_o         (mie),
    .mstatus_mie_o (mstatus_mie)
  );

  irq_arbiter u_arbiter (
    .mip_i         (mip),
    .mie_i         (mie),
    .mstatus_mie_i (mstatus_mie),
    .priv_lvl_i    (priv_lvl_i),
    .irq_ready_i   (irq_ready_i),
    .irq_valid_o   (irq_valid_o),
    .irq_id_o      (irq_id_o),
    .irq_ack_o     (irq_ack_o),
    .trap_o        (trap),
    .irq_pending_o (irq_pending)
  );

  // --------------------------------------------------
  // Bus activity and sleep
  // --------------------------------------------------
  obi_outstanding_counter #(
    .CNT_W (`OBI_CNT_W)
  ) u_iside_cnt (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (iside_req_i),
    .gnt_i    (iside_gnt_i),
    .rvalid_i (iside_rvalid_i),
    .busy_o   (iside_busy)
  );

  obi_outstanding_counter #(
    .CNT_W (`OBI_CNT_W)
  ) u_dside_cnt (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .req_i    (dside_req_i),
    .gnt_i    (dside_gnt_i),
    .rvalid_i (dside_rvalid_i),
    .busy_o   (dside_busy)
  );

  // Any pending-and-enabled line wakes, whatever the global enable
  wfi_sleep_ctrl u_sleep (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .wb_valid_i      (wb_valid_i),
    .wb_instr_i      (wb_instr_i),
    .wb_err_i        (wb_err_i),
    .wb_mpu_status_i (wb_mpu_status_i),
    .wb_kill_i       (wb_kill_i),
    .debug_mode_i    (debug_mode_i),
    .debug_req_i     (debug_req_i),
    .dcsr_step_i     (dcsr_step_i),
    .priv_lvl_i      (priv_lvl_i),
    .mstatus_tw_i    (mstatus_tw_i),
    .irq_wake_i      (irq_pending),
    .iside_busy_i    (iside_busy),
    .dside_busy_i    (dside_busy),
    .wbuf_empty_i    (wbuf_empty_i),
    .core_sleep_o    (core_sleep_o)
  );

endmodule

`default_nettype wire

/* hdl/obi_outstanding_counter.sv */
/*
 * OBI outstanding transaction counter
 * Tracks granted requests not yet answered on one bus side
 */
`timescale 1ns/100ps
`default_nettype none

module obi_outstanding_counter #(
  parameter int unsigned CNT_W = 4
) (
  input  wire  clk_i,
  input  wire  rst_ni,
  input  wire  req_i,
  input  wire  gnt_i,
  input  wire  rvalid_i,
  output logic busy_o
);

  logic [CNT_W-1:0] cnt_q;
  logic             issue;
  logic             nonzero_q;

  assign issue = req_i && gnt_i;

  // Issue and response in one cycle cancel out
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q     <= '0;
      nonzero_q <= 1'b0;
    end else begin
      if (issue && !rvalid_i) begin
        cnt_q <= cnt_q + 1'b1;
      end else if (!issue && rvalid_i) begin
        cnt_q <= cnt_q - 1'b1;
      end
      nonzero_q <= |cnt_q;
    end
  end

  // Busy stretches one cycle past the drain
  assign busy_o = (|cnt_q) || nonzero_q;

endmodule

`default_nettype wire

/* irq/irq_arbiter.sv */
/*
 * Fixed-priority interrupt arbiter
 * Picks the winning pending-and-enabled line, gates it by
 * privilege and global enable, and runs the valid/ready offer
 */
`timescale 1ns/100ps
`default_nettype none

`include "irq_macros.svh"

module irq_arbiter (
  input  wire [`IRQ_NUM-1:0] mip_i,
  input  wire [`IRQ_NUM-1:0] mie_i,
  input  wire                mstatus_mie_i,
  input  irq_pkg::priv_lvl_e priv_lvl_i,
  input  wire                irq_ready_i,
  output logic               irq_valid_o,
  output irq_pkg::irq_id_t   irq_id_o,
  output logic               irq_ack_o,
  output logic               trap_o,
  output logic               irq_pending_o
);

  import irq_pkg::*;

  logic [`IRQ_NUM-1:0] pend_en;
  logic                eligible;

  assign pend_en       = mip_i & mie_i;
  assign irq_pending_o = |pend_en;

  // --------------------------------------------------
  // Priority select
  // --------------------------------------------------

  // Order is 31 down to 16, then 11, 3, 7
  // Upper loop runs upward so the highest set line is kept
  always_comb begin
    irq_id_o = '0;
    if (|pend_en[31:16]) begin
      for (int i = 16; i < 32; i++) begin
        if (pend_en[i]) begin
          irq_id_o = irq_id_t'(i);
        end
      end
    end else if (pend_en[11]) begin
      irq_id_o = irq_id_t'(11);
    end else if (pend_en[3]) begin
      irq_id_o = irq_id_t'(3);
    end else if (pend_en[7]) begin
      irq_id_o = irq_id_t'(7);
    end
  end

  // --------------------------------------------------
  // Gating and handshake
  // --------------------------------------------------

  // M-mode needs the global enable, U-mode is always interruptible
  assign eligible = (priv_lvl_i == PRIV_LVL_U) || mstatus_mie_i;

  // Offer follows the live winner until the core takes it
  assign irq_valid_o = irq_pending_o && eligible;

  // Take happens in the valid and ready cycle
  assign irq_ack_o = irq_valid_o && irq_ready_i;
  // Same cycle strobe into the CSR block for trap entry
  assign trap_o    = irq_ack_o;

endmodule

`default_nettype wire

/* irq/irq_csr.sv */
/*
 * Interrupt CSR block
 * Holds MIP, MIE and the MSTATUS enable bits, serves CSR
 * reads and writes, and updates MSTATUS on trap entry and mret
 */
`timescale 1ns/100ps
`default_nettype none

`include "irq_macros.svh"

module irq_csr (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire [`IRQ_NUM-1:0]    irq_i,
  input  wire                   csr_we_i,
  input  irq_pkg::csr_addr_e    csr_addr_i,
  input  wire [31:0]            csr_wdata_i,
  input  wire                   trap_i,
  input  wire                   mret_i,
  output logic [31:0]           csr_rdata_o,
  output logic [31:0]           mip_o,
  output logic [31:0]           mie_o,
  output logic                  mstatus_mie_o
);

  import irq_pkg::*;

  // MSTATUS bit positions
  localparam int unsigned MSTATUS_MIE_BIT  = 3;
  localparam int unsigned MSTATUS_MPIE_BIT = 7;

  logic [31:0] mip_q;
  logic [31:0] mie_q;
  logic        mstatus_mie_q;
  logic        mstatus_mpie_q;

  // --------------------------------------------------
  // Pending and enable words
  // --------------------------------------------------

  // MIP is a flopped copy of the lines, reserved bits forced low
  // MIP is read-only, writes to it are dropped
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mip_q <= '0;
      mie_q <= '0;
    end else begin
      mip_q <= irq_i & `IRQ_VALID_MASK;
      if (csr_we_i && (csr_addr_i == CSR_MIE)) begin
        mie_q <= csr_wdata_i & `IRQ_VALID_MASK;
      end
    end
  end

  // --------------------------------------------------
  // MSTATUS enable and saved enable
  // --------------------------------------------------

  // Trap entry wins over mret and over a software write
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mstatus_mie_q  <= 1'b0;
      mstatus_mpie_q <= 1'b0;
    end else if (trap_i) begin
      mstatus_mpie_q <= mstatus_mie_q;
      mstatus_mie_q  <= 1'b0;
    end else if (mret_i) begin
      // Saved bit goes back to set, as on any mret
      mstatus_mie_q  <= mstatus_mpie_q;
      mstatus_mpie_q <= 1'b1;
    end else if (csr_we_i && (csr_addr_i == CSR_MSTATUS)) begin
      mstatus_mie_q  <= csr_wdata_i[MSTATUS_MIE_BIT];
      mstatus_mpie_q <= csr_wdata_i[MSTATUS_MPIE_BIT];
    end
  end

  // Read mux
  // Unmapped select reads zero
  always_comb begin
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_MSTATUS: begin
        csr_rdata_o[MSTATUS_MIE_BIT]  = mstatus_mie_q;
        csr_rdata_o[MSTATUS_MPIE_BIT] = mstatus_mpie_q;
      end
      CSR_MIE: csr_rdata_o = mie_q;
      CSR_MIP: csr_rdata_o = mip_q;
      default: csr_rdata_o = '0;
    endcase
  end

  assign mip_o         = mip_q;
  assign mie_o         = mie_q;
  assign mstatus_mie_o = mstatus_mie_q;

endmodule

`default_nettype wire

/* sleep/wfi_sleep_ctrl.sv */
/*
 * WFI/WFE sleep controller
 * Qualifies a wait instruction in writeback, lets it settle for
 * SLEEP_DELAY cycles with the buses idle, then raises core sleep
 */
`timescale 1ns/100ps
`default_nettype none

`include "irq_macros.svh"

module wfi_sleep_ctrl (
  input  wire                   clk_i,
  input  wire                   rst_ni,
  input  wire                   wb_valid_i,
  input  wire [31:0]            wb_instr_i,
  input  wire                   wb_err_i,
  input  irq_pkg::mpu_status_e  wb_mpu_status_i,
  input  wire                   wb_kill_i,
  input  wire                   debug_mode_i,
  input  wire                   debug_req_i,
  input  wire                   dcsr_step_i,
  input  irq_pkg::priv_lvl_e    priv_lvl_i,
  input  wire                   mstatus_tw_i,
  input  wire                   irq_wake_i,
  input  wire                   iside_busy_i,
  input  wire                   dside_busy_i,
  input  wire                   wbuf_empty_i,
  output logic                  core_sleep_o
);

  import irq_pkg::*;

  localparam int unsigned SETTLE_W = $clog2(`SLEEP_DELAY + 1);

  instr_kind_e         wb_kind;
  logic                qualified;
  logic                wake;
  logic                block;
  logic                hold;
  sleep_state_e        state_q, state_d;
  logic [SETTLE_W-1:0] settle_q, settle_d;
  logic                core_sleep_q;

  // --------------------------------------------------
  // Writeback decode and qualification
  // --------------------------------------------------
  always_comb begin
    case (wb_instr_i)
      `WFI_INSTR: wb_kind = INSTR_WFI;
      `WFE_INSTR: wb_kind = INSTR_WFE;
      default:    wb_kind = INSTR_OTHER;
    endcase
  end

  // U-mode with TW set must trap instead of waiting
  assign qualified = wb_valid_i && (wb_kind != INSTR_OTHER) && !wb_err_i &&
                     (wb_mpu_status_i == MPU_OK) && !wb_kill_i && !debug_mode_i &&
                     !dcsr_step_i && !((priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i);

  assign wake  = irq_wake_i || debug_req_i;
  // Any bus still busy or buffered write pending keeps the core up
  assign block = iside_busy_i || dside_busy_i || !wbuf_empty_i;
  assign hold  = qualified && !wake && !block;

  // --------------------------------------------------
  // Sleep FSM
  // --------------------------------------------------

  // First hold cycle loads the counter with 1
  // sleep is reached at the end of hold cycle SLEEP_DELAY+1
  always_comb begin
    state_d  = state_q;
    settle_d = settle_q;
    case (state_q)
      SLEEP_AWAKE: begin
        if (hold) begin
          state_d  = SLEEP_SETTLE;
          settle_d = SETTLE_W'(1);
        end
      end
      SLEEP_SETTLE: begin
        if (!hold) begin
          state_d  = SLEEP_AWAKE;
          settle_d = '0;
        end else if (settle_q == SETTLE_W'(`SLEEP_DELAY)) begin
          state_d  = SLEEP_ASLEEP;
          settle_d = '0;
        end else begin
          settle_d = settle_q + 1'b1;
        end
      end
      SLEEP_ASLEEP: begin
        // Wake, block or instruction gone all end sleep
        if (!hold) begin
          state_d = SLEEP_AWAKE;
        end
      end
      default: begin
        state_d  = SLEEP_AWAKE;
        settle_d = '0;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= SLEEP_AWAKE;
      settle_q     <= '0;
      core_sleep_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      settle_q     <= settle_d;
      core_sleep_q <= (state_d == SLEEP_ASLEEP);
    end
  end

  assign core_sleep_o = core_sleep_q;

endmodule

`default_nettype wire

/* testbench/tb_irq_sleep_model.svh */
/*
 * Reference model for the interrupt and sleep unit
 * Tracks MIP, MIE, the MSTATUS bits, both OBI counts and the
 * run of qualified wait cycles, and predicts the checked outputs
 */
`ifndef TB_IRQ_SLEEP_MODEL_SVH
`define TB_IRQ_SLEEP_MODEL_SVH

logic [31:0] m_mip;
logic [31:0] m_mie;
logic        m_gie;
logic        m_mpie;
int          m_cnt_i;
int          m_cnt_d;
bit          m_nz_i;
bit          m_nz_d;
int          m_run;
bit          m_sleep;

task automatic clear_model();
  m_mip   = '0;
  m_mie   = '0;
  m_gie   = 1'b0;
  m_mpie  = 1'b0;
  m_cnt_i = 0;
  m_cnt_d = 0;
  m_nz_i  = 1'b0;
  m_nz_d  = 1'b0;
  m_run   = 0;
  m_sleep = 1'b0;
endtask

// Priority order 31 down to 16, then 11, 3, 7
function automatic logic [4:0] top_priority_line(input logic [31:0] pe);
  for (int i = 31; i >= 16; i--) begin
    if (pe[i]) return i[4:0];
  end
  if (pe[11]) return 5'd11;
  if (pe[3]) return 5'd3;
  if (pe[7]) return 5'd7;
  return 5'd0;
endfunction

// Offer needs a pending line, and in M-mode the global enable
function automatic logic offer_expected();
  return (|(m_mip & m_mie)) && ((priv_lvl_i == PRIV_LVL_U) || m_gie);
endfunction

function automatic logic [31:0] csr_read_value();
  case (csr_addr_i)
    CSR_MSTATUS: return {24'h0, m_mpie, 3'b000, m_gie, 3'b000};
    CSR_MIE:     return m_mie;
    CSR_MIP:     return m_mip;
    default:     return 32'h0;
  endcase
endfunction

// A cycle that counts toward sleep
function automatic logic counts_toward_sleep();
  logic qual;
  logic wake;
  logic block;
  qual  = wb_valid_i && ((wb_instr_i == `WFI_INSTR) || (wb_instr_i == `WFE_INSTR)) &&
          !wb_err_i && (wb_mpu_status_i == MPU_OK) && !wb_kill_i && !debug_mode_i &&
          !dcsr_step_i && !((priv_lvl_i == PRIV_LVL_U) && mstatus_tw_i);
  wake  = (|(m_mip & m_mie)) || debug_req_i;
  block = (m_cnt_i != 0) || m_nz_i || (m_cnt_d != 0) || m_nz_d || !wbuf_empty_i;
  return qual && !wake && !block;
endfunction

// Clock edge update from the inputs of the cycle that just ended
task automatic step_model();
  logic take;
  logic hold;
  take = offer_expected() && irq_ready_i;
  hold = counts_toward_sleep();
  if (take) begin
    m_mpie = m_gie;
    m_gie  = 1'b0;
  end else if (mret_i) begin
    m_gie  = m_mpie;
    m_mpie = 1'b1;
  end else if (csr_we_i && (csr_addr_i == CSR_MSTATUS)) begin
    m_gie  = csr_wdata_i[3];
    m_mpie = csr_wdata_i[7];
  end
  if (csr_we_i && (csr_addr_i == CSR_MIE)) m_mie = csr_wdata_i & `IRQ_VALID_MASK;
  m_mip   = irq_i & `IRQ_VALID_MASK;
  m_nz_i  = (m_cnt_i != 0);
  m_nz_d  = (m_cnt_d != 0);
  m_cnt_i = m_cnt_i + int'(iside_req_i && iside_gnt_i) - int'(iside_rvalid_i);
  m_cnt_d = m_cnt_d + int'(dside_req_i && dside_gnt_i) - int'(dside_rvalid_i);
  // Sleep after SLEEP_DELAY+1 hold cycles in a row
  m_run   = hold ? ((m_run < 100) ? m_run + 1 : m_run) : 0;
  m_sleep = hold && (m_run > `SLEEP_DELAY);
endtask

`endif

/* testbench/tb_irq_sleep.sv */
/*
 * Testbench for the interrupt and sleep unit
 * Directed sleep, wake and handshake sequence, then random
 * segments checked cycle by cycle against the included model
 */
`timescale 1ns/100ps
`default_nettype none

`include "irq_macros.svh"

module tb_irq_sleep;

  import irq_pkg::*;

  logic        clk_i;
  logic        rst_ni;
  logic [31:0] irq_i;
  logic        irq_ready_i;
  logic        irq_valid_o;
  irq_id_t     irq_id_o;
  logic        irq_ack_o;
  logic        csr_we_i;
  csr_addr_e   csr_addr_i;
  logic [31:0] csr_wdata_i;
  logic [31:0] csr_rdata_o;
  logic        mret_i;
  priv_lvl_e   priv_lvl_i;
  logic        mstatus_tw_i;
  logic        wb_valid_i;
  logic [31:0] wb_instr_i;
  logic        wb_err_i;
  mpu_status_e wb_mpu_status_i;
  logic        wb_kill_i;
  logic        debug_mode_i;
  logic        debug_req_i;
  logic        dcsr_step_i;
  logic        iside_req_i;
  logic        iside_gnt_i;
  logic        iside_rvalid_i;
  logic        dside_req_i;
  logic        dside_gnt_i;
  logic        dside_rvalid_i;
  logic        wbuf_empty_i;
  logic        core_sleep_o;
  int          errors;
  logic        ack_prev;
  int          n;

  `include "tb_irq_sleep_model.svh"

  irq_sleep_top DUT (
    .clk_i (clk_i), .rst_ni (rst_ni), .irq_i (irq_i), .irq_ready_i (irq_ready_i),
    .irq_valid_o (irq_valid_o), .irq_id_o (irq_id_o), .irq_ack_o (irq_ack_o),
    .csr_we_i (csr_we_i), .csr_addr_i (csr_addr_i), .csr_wdata_i (csr_wdata_i),
    .csr_rdata_o (csr_rdata_o), .mret_i (mret_i), .priv_lvl_i (priv_lvl_i),
    .mstatus_tw_i (mstatus_tw_i), .wb_valid_i (wb_valid_i), .wb_instr_i (wb_instr_i),
    .wb_err_i (wb_err_i), .wb_mpu_status_i (wb_mpu_status_i), .wb_kill_i (wb_kill_i),
    .debug_mode_i (debug_mode_i), .debug_req_i (debug_req_i), .dcsr_step_i (dcsr_step_i),
    .iside_req_i (iside_req_i), .iside_gnt_i (iside_gnt_i), .iside_rvalid_i (iside_rvalid_i),
    .dside_req_i (dside_req_i), .dside_gnt_i (dside_gnt_i), .dside_rvalid_i (dside_rvalid_i),
    .wbuf_empty_i (wbuf_empty_i), .core_sleep_o (core_sleep_o)
  );

  // 4 ns clock
  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic bit one_in(input int unsigned k);
    return ($urandom % k) == 0;
  endfunction

  task automatic check_value(input string name, input logic [31:0] act, input logic [31:0] exp);
    if (act !== exp) begin
      errors++;
      $display("ERR %0t %s actual=%h expected=%h", $time, name, act, exp);
    end
  endtask

  task automatic report_timeout(input string what);
    errors++;
    $display("Timeout at %0t while waiting for %s", $time, what);
  endtask

  // Edge, model update, then the drive point 1 ns later
  task automatic advance();
    @(posedge clk_i);
    step_model();
    #1;
  endtask

  task automatic check_outputs();
    logic exp_valid;
    #2;
    exp_valid = offer_expected();
    check_value("irq_valid_o", irq_valid_o, exp_valid);
    if (exp_valid) check_value("irq_id_o", irq_id_o, top_priority_line(m_mip & m_mie));
    check_value("irq_ack_o", irq_ack_o, exp_valid && irq_ready_i);
    check_value("irq_ack_o twice", irq_ack_o && ack_prev && (priv_lvl_i == PRIV_LVL_M), 0);
    ack_prev = irq_ack_o;
    check_value("csr_rdata_o", csr_rdata_o, csr_read_value());
    // Reserved MIP bits never show
    if (csr_addr_i == CSR_MIP) check_value("mip reserved", csr_rdata_o & ~`IRQ_VALID_MASK, 0);
    check_value("core_sleep_o", core_sleep_o, m_sleep);
  endtask

  task automatic idle_inputs();
    irq_i = '0;
    irq_ready_i = 1'b0;
    csr_we_i = 1'b0;
    csr_addr_i = CSR_MIP;
    csr_wdata_i = '0;
    mret_i = 1'b0;
    priv_lvl_i = PRIV_LVL_M;
    mstatus_tw_i = 1'b0;
    wb_valid_i = 1'b0;
    wb_instr_i = '0;
    wb_err_i = 1'b0;
    wb_mpu_status_i = MPU_OK;
    wb_kill_i = 1'b0;
    debug_mode_i = 1'b0;
    debug_req_i = 1'b0;
    dcsr_step_i = 1'b0;
    {iside_req_i, iside_gnt_i, iside_rvalid_i} = 3'b000;
    {dside_req_i, dside_gnt_i, dside_rvalid_i} = 3'b000;
    wbuf_empty_i = 1'b1;
  endtask

  // Responses only while something is outstanding and issues capped below overflow
  task automatic bus_stimulus(input int cnt, input bit quiet,
                              output logic req, output logic gnt, output logic rvalid);
    req    = one_in(quiet ? 32 : 2);
    gnt    = (cnt < 14) && one_in(2);
    rvalid = (cnt > 0) && (quiet ? !one_in(4) : one_in(2));
  endtask

  // Mode 0 plain random, 1 leans toward sleep, 2 leans toward interrupts
  task automatic drive_random(input int mode);
    bit          quiet;
    int unsigned rare;
    quiet = (mode == 1);
    rare  = quiet ? 32 : 4;
    irq_ready_i = (mode == 2) ? one_in(3) : one_in(2);
    priv_lvl_i = one_in(quiet ? 8 : 2) ? PRIV_LVL_U : PRIV_LVL_M;
    mstatus_tw_i = one_in(2);
    csr_we_i = one_in(quiet ? 16 : 4);
    csr_addr_i = csr_addr_e'($urandom_range(2, 0));
    csr_wdata_i = $urandom;
    mret_i = one_in(quiet ? 64 : 8);
    wb_valid_i = !one_in(rare);
    case ($urandom % 8)
      0:       wb_instr_i = $urandom;
      1, 2, 3: wb_instr_i = `WFE_INSTR;
      default: wb_instr_i = `WFI_INSTR;
    endcase
    wb_err_i = one_in(rare);
    wb_kill_i = one_in(rare);
    debug_mode_i = one_in(rare);
    dcsr_step_i = one_in(rare);
    wb_mpu_status_i = one_in(rare) ? mpu_status_e'($urandom_range(2, 1)) : MPU_OK;
    debug_req_i = one_in(rare * 2);
    if (quiet) irq_i = one_in(24) ? (32'h1 << $urandom_range(31, 0)) : '0;
    else irq_i = $urandom & $urandom;
    wbuf_empty_i = !one_in(quiet ? 32 : 3);
    bus_stimulus(m_cnt_i, quiet, iside_req_i, iside_gnt_i, iside_rvalid_i);
    bus_stimulus(m_cnt_d, quiet, dside_req_i, dside_gnt_i, dside_rvalid_i);
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    errors   = 0;
    ack_prev = 1'b0;
    void'($urandom(32'h0150_f217));
    idle_inputs();
    clear_model();
    rst_ni = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 rst_ni = 1'b1;
    check_outputs();

    // Enable every line and the global enable
    advance();
    csr_we_i = 1'b1;
    csr_addr_i = CSR_MIE;
    csr_wdata_i = '1;
    check_outputs();
    advance();
    csr_addr_i = CSR_MSTATUS;
    csr_wdata_i = 32'h8;
    check_outputs();

    // Clean WFI with idle buses goes to sleep
    advance();
    csr_we_i = 1'b0;
    wb_valid_i = 1'b1;
    wb_instr_i = `WFI_INSTR;
    check_outputs();
    n = 0;
    while (!core_sleep_o && n < 10) begin
      advance();
      check_outputs();
      n++;
    end
    if (!core_sleep_o) report_timeout("core_sleep_o to rise on a clean WFI");

    // External line wakes the core and is offered
    advance();
    irq_i = 32'h800;
    check_outputs();
    n = 0;
    while ((core_sleep_o || !irq_valid_o) && n < 6) begin
      advance();
      check_outputs();
      n++;
    end
    if (core_sleep_o || !irq_valid_o) report_timeout("wake and interrupt offer");

    // Back-pressure keeps the offer, then the core takes it
    repeat (4) begin
      advance();
      check_outputs();
    end
    advance();
    wb_valid_i = 1'b0;
    irq_ready_i = 1'b1;
    check_outputs();
    n = 0;
    while (!irq_ack_o && n < 6) begin
      advance();
      check_outputs();
      n++;
    end
    if (!irq_ack_o) report_timeout("irq_ack_o after raising ready");
    advance();
    irq_ready_i = 1'b0;
    check_outputs();
    check_value("mstatus after take", csr_rdata_o, 32'h80);
    advance();
    mret_i = 1'b1;
    check_outputs();
    advance();
    mret_i = 1'b0;
    check_outputs();
    check_value("mstatus.mie after mret", csr_rdata_o & 32'h8, 32'h8);

    // Random segments
    for (int seg = 0; seg < 48; seg++) begin
      repeat (64) begin
        advance();
        drive_random(seg % 3);
        check_outputs();
      end
    end

    $display("Error count: %0d", errors);
    if (errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire
